// ==== byte_concat.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_concat (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [loader_pkg::byte_w-1:0] in_byte,
    input  logic                          clear,
    output logic                          word_valid,
    output logic [loader_pkg::word_w-1:0] word
);
    import loader_pkg::*;

    localparam int lanes = word_w / byte_w;
    localparam int lane_w = $clog2(lanes);

    logic [lane_w-1:0] lane;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (clear) begin
                // drop whatever partial word is left
                lane <= '0;
            end else if (in_valid) begin
                lane <= lane + 1'b1;
                word_valid <= (lane == lane_w'(lanes - 1));
            end
        end
    end

    // new byte enters at the top, so the first byte ends up in [7:0]
    always_ff @(posedge clk) begin
        if (in_valid) begin
            word <= {in_byte, word[word_w-1:byte_w]};
        end
    end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic                              clk,
    input  logic                              rst,
    input  loader_pkg::mem_wr_t               imem_wr,
    input  loader_pkg::mem_wr_t               dmem_wr,
    input  logic [loader_pkg::mem_addr_w:0]   instr_count,
    input  logic                              exec_start,
    input  logic [loader_pkg::mem_addr_w:0]   word_count,
    output logic                              exec_done,
    input  logic                              res_re,
    input  logic [loader_pkg::mem_addr_w-1:0] res_addr,
    output logic [loader_pkg::word_w-1:0]     res_word
);
    import loader_pkg::*;

    logic [word_w-1:0] imem [imem_depth];
    logic [word_w-1:0] dmem [dmem_depth];
    logic running;
    logic [mem_addr_w:0] idx;
    logic [mem_addr_w:0] n_words;
    logic [mem_addr_w:0] n_instr;
    instr_t cur;
    logic [word_w-1:0] imm;
    logic [word_w-1:0] cur_data;
    logic [word_w-1:0] new_data;

    assign cur = instr_t'(imem[idx[mem_addr_w-1:0]]);
    assign cur_data = dmem[idx[mem_addr_w-1:0]];
    assign imm = word_w'(cur.imm);

    always_comb begin
        new_data = cur_data;
        // words past the program length pass through
        if (idx < n_instr) begin
            case (cur.op)
                op_add: new_data = cur_data + imm;
                op_xor: new_data = cur_data ^ imm;
                op_shl: new_data = cur_data << imm[4:0];
                default: new_data = cur_data;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (imem_wr.we) begin
            imem[imem_wr.addr] <= imem_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            dmem[idx[mem_addr_w-1:0]] <= new_data;
        end else if (dmem_wr.we) begin
            dmem[dmem_wr.addr] <= dmem_wr.data;
        end
        if (res_re) begin
            res_word <= dmem[res_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (exec_start) begin
            n_words <= word_count;
            n_instr <= instr_count;
        end
    end

    // one data word per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            exec_done <= 1'b0;
            idx <= '0;
        end else begin
            exec_done <= 1'b0;
            if (exec_start) begin
                idx <= '0;
                running <= (word_count != '0);
                exec_done <= (word_count == '0);
            end else if (running) begin
                idx <= idx + 1'b1;
                if (idx == n_words - 1'b1) begin
                    running <= 1'b0;
                    exec_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
loader_pkg.sv
byte_concat.sv
word_fifo.sv
io_fsm.sv
exec_core.sv
result_serializer.sv
loader_top.sv
tb_loader.sv

// ==== io_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_fsm (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rx_valid,
    input  logic                              word_valid,
    input  logic                              fifo_empty,
    input  logic                              exec_done,
    input  logic                              tx_busy,
    input  logic [loader_pkg::word_w-1:0]     res_word,
    output logic                              concat_clear,
    output logic                              fifo_we,
    output logic                              fifo_re,
    output loader_pkg::mem_wr_t               imem_wr,
    output loader_pkg::mem_wr_t               dmem_wr,
    output logic                              exec_start,
    output logic [loader_pkg::mem_addr_w:0]   word_count,
    output logic                              res_re,
    output logic [loader_pkg::mem_addr_w-1:0] res_addr,
    output logic                              tx_load,
    output loader_pkg::tx_job_t               tx_job
);
    import loader_pkg::*;

    localparam int idle_w = $clog2(rx_timeout_cycles + 1);

    typedef enum logic [2:0] {
        send_program_marker,
        program_receive,
        send_data_marker,
        data_receive,
        exec,
        result_read,
        result_send
    } state_e;

    state_e state;
    state_e n_state;
    logic [idle_w-1:0] idle_cnt;
    logic empty_d1;
    logic empty_d2;
    logic [mem_addr_w-1:0] instr_addr;
    logic [mem_addr_w-1:0] data_addr;
    logic [mem_addr_w:0] data_cnt;
    logic [mem_addr_w:0] res_idx;
    logic receiving;
    logic rx_done;
    logic last_result;

    assign receiving = (state == program_receive) || (state == data_receive);
    // link idle long enough and nothing left in the fifo or its read pipe
    assign rx_done = (idle_cnt == idle_w'(rx_timeout_cycles)) && fifo_empty &&
                     empty_d1 && empty_d2;
    assign last_result = (res_idx == data_cnt - 1'b1);

    always_comb begin
        n_state = state;
        case (state)
            send_program_marker: if (!tx_busy) n_state = program_receive;
            program_receive: if (rx_done) n_state = send_data_marker;
            send_data_marker: if (!tx_busy) n_state = data_receive;
            data_receive: if (rx_done) n_state = exec;
            exec: begin
                if (exec_done) begin
                    n_state = (data_cnt == '0) ? send_program_marker : result_read;
                end
            end
            result_read: n_state = result_send;
            result_send: begin
                if (!tx_busy) begin
                    n_state = last_result ? send_program_marker : result_read;
                end
            end
            default: n_state = send_program_marker;
        endcase
    end

    assign concat_clear = !receiving;
    assign fifo_we = receiving && word_valid;
    // read is held through the phase; data shows up two cycles later
    assign fifo_re = receiving;
    assign exec_start = (state == data_receive) && rx_done;
    assign word_count = data_cnt;
    assign res_re = (state == result_read);
    assign res_addr = res_idx[mem_addr_w-1:0];

    // payload joins from the fifo at the top level
    assign imem_wr = '{we: (state == program_receive) && !empty_d2, addr: instr_addr,
                       data: '0};
    assign dmem_wr = '{we: (state == data_receive) && !empty_d2, addr: data_addr,
                       data: '0};

    always_comb begin
        tx_load = 1'b0;
        tx_job = '{payload: res_word, count: tx_count_w'(4)};
        case (state)
            send_program_marker: begin
                tx_load = !tx_busy;
                tx_job = '{payload: word_w'(marker_program), count: tx_count_w'(1)};
            end
            send_data_marker: begin
                tx_load = !tx_busy;
                tx_job = '{payload: word_w'(marker_data), count: tx_count_w'(1)};
            end
            result_send: tx_load = !tx_busy;
            default: tx_load = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= send_program_marker;
            empty_d1 <= 1'b1;
            empty_d2 <= 1'b1;
            idle_cnt <= '0;
            instr_addr <= '0;
            data_addr <= '0;
            data_cnt <= '0;
            res_idx <= '0;
        end else begin
            state <= n_state;
            empty_d1 <= fifo_empty;
            empty_d2 <= empty_d1;

            // marker still going out counts as activity
            if (!receiving || rx_valid || tx_busy) begin
                idle_cnt <= '0;
            end else if (idle_cnt != idle_w'(rx_timeout_cycles)) begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            if (state == send_program_marker) begin
                instr_addr <= '0;
                data_addr <= '0;
                data_cnt <= '0;
                res_idx <= '0;
            end else begin
                if (imem_wr.we) begin
                    instr_addr <= instr_addr + 1'b1;
                end
                if (dmem_wr.we) begin
                    data_addr <= data_addr + 1'b1;
                    // count saturates, addresses wrap
                    if (data_cnt != (mem_addr_w + 1)'(dmem_depth)) begin
                        data_cnt <= data_cnt + 1'b1;
                    end
                end
                if (state == result_send && !tx_busy) begin
                    res_idx <= res_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== loader_pkg.sv ====
`default_nettype none

package loader_pkg;

    localparam int word_w = 32;
    localparam int byte_w = 8;
    localparam int imem_depth = 16;
    localparam int dmem_depth = 16;
    localparam int mem_addr_w = 4;
    localparam int fifo_depth = 8;
    localparam int rx_timeout_cycles = 32;
    localparam int tx_count_w = 3;

    localparam logic [byte_w-1:0] marker_program = 8'h99;
    localparam logic [byte_w-1:0] marker_data = 8'haa;

    typedef enum logic [1:0] {
        op_add,
        op_xor,
        op_shl,
        op_pass
    } opcode_e;

    // immediate is zero-extended when applied
    typedef struct packed {
        logic [23:0] imm;
        logic [5:0]  unused;
        opcode_e     op;
    } instr_t;

    // count is 1 for a marker, 4 for a result word
    typedef struct packed {
        logic [word_w-1:0]     payload;
        logic [tx_count_w-1:0] count;
    } tx_job_t;

    typedef struct packed {
        logic                  we;
        logic [mem_addr_w-1:0] addr;
        logic [word_w-1:0]     data;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rx_valid,
    input  logic [loader_pkg::byte_w-1:0] rx_byte,
    input  logic                          tx_ready,
    output logic                          tx_valid,
    output logic [loader_pkg::byte_w-1:0] tx_byte
);
    import loader_pkg::*;

    logic concat_clear;
    logic word_valid;
    logic [word_w-1:0] word;
    logic fifo_we;
    logic fifo_re;
    logic fifo_empty;
    logic [word_w-1:0] fifo_rdata;
    mem_wr_t imem_ctl;
    mem_wr_t dmem_ctl;
    mem_wr_t imem_wr;
    mem_wr_t dmem_wr;
    logic exec_start;
    logic exec_done;
    logic [mem_addr_w:0] word_count;
    logic res_re;
    logic [mem_addr_w-1:0] res_addr;
    logic [word_w-1:0] res_word;
    logic tx_load;
    logic tx_busy;
    tx_job_t tx_job;

    // write strobe and address from the fsm, word from the fifo
    always_comb begin
        imem_wr = imem_ctl;
        imem_wr.data = fifo_rdata;
        dmem_wr = dmem_ctl;
        dmem_wr.data = fifo_rdata;
    end

    byte_concat u_concat (
        .clk(clk), .rst(rst), .in_valid(rx_valid), .in_byte(rx_byte),
        .clear(concat_clear), .word_valid(word_valid), .word(word)
    );

    word_fifo u_fifo (
        .clk(clk), .rst(rst), .we(fifo_we), .wdata(word), .re(fifo_re),
        .rdata(fifo_rdata), .empty(fifo_empty), .full()
    );

    io_fsm u_fsm (
        .clk(clk), .rst(rst), .rx_valid(rx_valid), .word_valid(word_valid),
        .fifo_empty(fifo_empty), .exec_done(exec_done), .tx_busy(tx_busy),
        .res_word(res_word), .concat_clear(concat_clear), .fifo_we(fifo_we),
        .fifo_re(fifo_re), .imem_wr(imem_ctl), .dmem_wr(dmem_ctl),
        .exec_start(exec_start), .word_count(word_count), .res_re(res_re),
        .res_addr(res_addr), .tx_load(tx_load), .tx_job(tx_job)
    );

    // instruction count is the instruction address counter
    exec_core u_core (
        .clk(clk), .rst(rst), .imem_wr(imem_wr), .dmem_wr(dmem_wr),
        .instr_count({1'b0, imem_ctl.addr}), .exec_start(exec_start),
        .word_count(word_count), .exec_done(exec_done), .res_re(res_re),
        .res_addr(res_addr), .res_word(res_word)
    );

    result_serializer u_ser (
        .clk(clk), .rst(rst), .tx_load(tx_load), .tx_job(tx_job),
        .tx_ready(tx_ready), .tx_valid(tx_valid), .tx_byte(tx_byte), .tx_busy(tx_busy)
    );

endmodule

`default_nettype wire

// ==== result_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_serializer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          tx_load,
    input  loader_pkg::tx_job_t           tx_job,
    input  logic                          tx_ready,
    output logic                          tx_valid,
    output logic [loader_pkg::byte_w-1:0] tx_byte,
    output logic                          tx_busy
);
    import loader_pkg::*;

    logic [word_w-1:0] shift;
    logic [tx_count_w-1:0] left;

    // a byte goes out only when the host is ready
    assign tx_valid = tx_busy && tx_ready;
    assign tx_byte = shift[byte_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            left <= '0;
        end else if (tx_load) begin
            tx_busy <= (tx_job.count != '0);
            left <= tx_job.count;
        end else if (tx_valid) begin
            left <= left - 1'b1;
            if (left == tx_count_w'(1)) begin
                tx_busy <= 1'b0;
            end
        end
    end

    // lowest byte first
    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift <= tx_job.payload;
        end else if (tx_valid) begin
            shift <= shift >> byte_w;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the loader testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -f files.f \
        --top-module tb_loader -Mdir obj_dir -o sim_loader; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_loader)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1

// ==== tb_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_loader;

    localparam int num_jobs = 4;
    localparam int max_words = 8;
    localparam int wait_limit = 500;

    // operation field in the low two bits of an instruction word
    localparam logic [1:0] do_add = 2'd0;
    localparam logic [1:0] do_xor = 2'd1;
    localparam logic [1:0] do_shl = 2'd2;
    localparam logic [1:0] do_pass = 2'd3;

    logic clk;
    logic rst;
    logic rx_valid;
    logic [7:0] rx_byte;
    logic tx_ready;
    logic tx_valid;
    logic [7:0] tx_byte;

    // job table with program, data, extra bytes past the last whole word and back-pressure
    logic [31:0] prog_tab [num_jobs][max_words];
    logic [31:0] data_tab [num_jobs][max_words];
    int prog_len [num_jobs];
    int data_len [num_jobs];
    int tail_bytes [num_jobs];
    bit bp_flag [num_jobs];

    logic [7:0] rx_bytes[$];
    int errors;
    int tests_run;
    int tests_passed;
    bit aborted;

    loader_top uut (
        .clk(clk),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_byte(rx_byte),
        .tx_ready(tx_ready),
        .tx_valid(tx_valid),
        .tx_byte(tx_byte)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] make_instr(input logic [1:0] op, input logic [23:0] imm);
        return {imm, 6'b000000, op};
    endfunction

    // immediate is the upper 24 bits and is zero-extended
    function automatic logic [31:0] apply_instr(input logic [31:0] instr, input logic [31:0] d);
        logic [31:0] imm;
        imm = {8'h00, instr[31:8]};
        case (instr[1:0])
            do_add: return d + imm;
            do_xor: return d ^ imm;
            do_shl: return d << imm[4:0];
            default: return d;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic set_job(input int j, input int plen, input int dlen, input int tail,
                           input bit bp);
        prog_len[j] = plen;
        data_len[j] = dlen;
        tail_bytes[j] = tail;
        bp_flag[j] = bp;
    endtask

    task automatic fill_job_table();
        // every opcode once plus one data word past the program
        set_job(0, 4, 5, 0, 1'b0);
        prog_tab[0][0] = make_instr(do_add, 24'h000010);
        prog_tab[0][1] = make_instr(do_xor, 24'hff00ff);
        prog_tab[0][2] = make_instr(do_shl, 24'h000004);
        prog_tab[0][3] = make_instr(do_pass, 24'h123456);
        data_tab[0][0] = 32'h0000_0001;
        data_tab[0][1] = 32'h1234_5678;
        data_tab[0][2] = 32'h0f0f_0f0f;
        data_tab[0][3] = 32'hdead_beef;
        data_tab[0][4] = 32'hcafe_f00d;
        // shift amount uses only the low 5 bits of 0x25
        set_job(1, 3, 6, 3, 1'b1);
        prog_tab[1][0] = make_instr(do_shl, 24'h000025);
        prog_tab[1][1] = make_instr(do_add, 24'hffffff);
        prog_tab[1][2] = make_instr(do_xor, 24'h5a5a5a);
        data_tab[1][0] = 32'h0000_0003;
        data_tab[1][1] = 32'hffff_ffff;
        data_tab[1][2] = 32'h0000_0000;
        data_tab[1][3] = 32'h0102_0304;
        data_tab[1][4] = 32'h8000_0000;
        data_tab[1][5] = 32'h1357_9bdf;
        // empty program so old instructions must not leak in
        set_job(2, 0, 2, 2, 1'b1);
        data_tab[2][0] = 32'h89ab_cdef;
        data_tab[2][1] = 32'h0000_0042;
        // program longer than the data
        set_job(3, 4, 3, 1, 1'b0);
        prog_tab[3][0] = make_instr(do_xor, 24'h0000ff);
        prog_tab[3][1] = make_instr(do_add, 24'h000001);
        prog_tab[3][2] = make_instr(do_pass, 24'h000000);
        prog_tab[3][3] = make_instr(do_shl, 24'h000001);
        data_tab[3][0] = 32'hffff_ffff;
        data_tab[3][1] = 32'h7fff_ffff;
        data_tab[3][2] = 32'ha5a5_a5a5;
    endtask

    // one transmit-side cycle with the byte sampled mid-cycle
    task automatic tx_cycle(input bit bp, output bit got, output logic [7:0] b);
        @(posedge clk);
        #1;
        if (bp) begin
            tx_ready = ($urandom % 3) != 0;
        end else begin
            tx_ready = 1'b1;
        end
        @(negedge clk);
        got = tx_valid;
        b = tx_byte;
    endtask

    task automatic wait_tx_byte(input bit bp, output logic [7:0] b, output bit ok);
        int n;
        bit got;
        ok = 1'b0;
        n = 0;
        while (!ok && n < wait_limit) begin
            tx_cycle(bp, got, b);
            ok = got;
            n++;
        end
    endtask

    task automatic drive_rx(input logic v, input logic [7:0] b);
        @(posedge clk);
        #1;
        rx_valid = v;
        rx_byte = b;
        @(negedge clk);
        if (tx_valid) begin
            $display("unexpected byte 0x%02h sent while the host was sending", tx_byte);
            errors++;
        end
    endtask

    task automatic queue_phase(input int j, input bit data_phase);
        int n;
        logic [31:0] w;
        rx_bytes.delete();
        n = data_phase ? data_len[j] : prog_len[j];
        for (int i = 0; i < n; i++) begin
            w = data_phase ? data_tab[j][i] : prog_tab[j][i];
            for (int k = 0; k < 4; k++) begin
                rx_bytes.push_back(w[k*8 +: 8]);
            end
        end
        // bytes that never complete a word
        for (int k = 0; k < tail_bytes[j]; k++) begin
            rx_bytes.push_back(8'($urandom));
        end
    endtask

    task automatic send_rx_bytes();
        int gap;
        for (int i = 0; i < rx_bytes.size(); i++) begin
            // mostly short gaps and now and then a long one still under the timeout
            if ($urandom % 8 == 0) begin
                gap = int'($urandom % 24);
            end else begin
                gap = int'($urandom % 3);
            end
            for (int g = 0; g < gap; g++) begin
                drive_rx(1'b0, 8'h00);
            end
            drive_rx(1'b1, rx_bytes[i]);
        end
        drive_rx(1'b0, 8'h00);
    endtask

    task automatic run_job(input int j);
        logic [7:0] b;
        logic [31:0] w;
        bit ok;
        logic [31:0] exp_words[$];
        wait_tx_byte(bp_flag[j], b, ok);
        if (!ok) begin
            note_timeout("the program marker");
            return;
        end
        check_value("tx_byte (program marker)", {24'h0, b}, 32'h0000_0099);
        queue_phase(j, 1'b0);
        send_rx_bytes();
        wait_tx_byte(bp_flag[j], b, ok);
        if (!ok) begin
            note_timeout("the data marker");
            return;
        end
        check_value("tx_byte (data marker)", {24'h0, b}, 32'h0000_00aa);
        queue_phase(j, 1'b1);
        send_rx_bytes();
        // words past the program come back as they went in
        for (int i = 0; i < data_len[j]; i++) begin
            if (i < prog_len[j]) begin
                exp_words.push_back(apply_instr(prog_tab[j][i], data_tab[j][i]));
            end else begin
                exp_words.push_back(data_tab[j][i]);
            end
        end
        for (int i = 0; i < exp_words.size(); i++) begin
            w = '0;
            for (int k = 0; k < 4; k++) begin
                wait_tx_byte(bp_flag[j], b, ok);
                if (!ok) begin
                    note_timeout($sformatf("byte %0d of result word %0d", k, i));
                    return;
                end
                w[k*8 +: 8] = b;
            end
            check_value($sformatf("tx_byte (result word %0d)", i), w, exp_words[i]);
        end
    endtask

    initial begin
        int errs_before;
        logic [7:0] b;
        bit ok;
        void'($urandom(61425));
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_byte = 8'h00;
        tx_ready = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_passed = 0;
        aborted = 1'b0;
        fill_job_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int j = 0; j < num_jobs && !aborted; j++) begin
            errs_before = errors;
            run_job(j);
            tests_run++;
            if (errors == errs_before) begin
                tests_passed++;
            end
            $display("test %0d: %0d program words, %0d data words, %0d extra bytes: %s",
                     j, prog_len[j], data_len[j], tail_bytes[j],
                     (errors == errs_before) ? "ok" : "error");
        end

        // after the last result byte the next job starts with a fresh marker
        if (!aborted) begin
            errs_before = errors;
            wait_tx_byte(1'b0, b, ok);
            if (!ok) begin
                note_timeout("the program marker after the last job");
            end else begin
                check_value("tx_byte (restart marker)", {24'h0, b}, 32'h0000_0099);
            end
            tests_run++;
            if (errors == errs_before) begin
                tests_passed++;
            end
            $display("test %0d: restart marker: %s", num_jobs,
                     (errors == errs_before) ? "ok" : "error");
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [loader_pkg::word_w-1:0] wdata,
    input  logic                          re,
    output logic [loader_pkg::word_w-1:0] rdata,
    output logic                          empty,
    output logic                          full
);
    import loader_pkg::*;

    localparam int ptr_w = $clog2(fifo_depth);

    logic [word_w-1:0] mem [fifo_depth];
    logic [word_w-1:0] mem_q;
    // extra msb tells full from empty
    logic [ptr_w:0] wr_ptr;
    logic [ptr_w:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                  (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);
    assign do_write = we && !full;
    assign do_read = re && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[ptr_w-1:0]] <= wdata;
        end
        // registered ram output, then output register, like a pipelined bram
        if (do_read) begin
            mem_q <= mem[rd_ptr[ptr_w-1:0]];
        end
        rdata <= mem_q;
    end

endmodule

`default_nettype wire
